// File: md5crypt_cmp.f
+incdir+include
source/pkt_comm_pkg.sv
source/cmp_pkg.sv
source/inpkt_header.sv
source/cmp_config.sv
source/comparator.sv
source/word_list.sv
source/outpkt.sv
source/md5crypt_cmp.sv
testbench/tb_md5crypt_cmp.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the md5crypt_cmp testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_md5crypt_cmp -f md5crypt_cmp.f -o sim_tb

# the log decides pass or fail
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log || ! grep -q "ALL TESTS PASSED" sim.log; then
	exit 1
fi

// File: source/cmp_config.sv
`timescale 1ns/1ns
`default_nettype none

module cmp_config #(
	parameter int HASH_COUNT_MAX = 16
)(
	input wire PKT_COMM_CLK,
	input wire rst_n,
	input wire [7:0] din,
	input wire wr_en,                     // CMP_CONFIG payload byte
	input wire pkt_end,
	output logic tbl_wr_en,
	output cmp_pkg::hash_num_t tbl_addr,
	output cmp_pkg::hash_t tbl_din,
	output cmp_pkg::hash_num_t hash_count,
	output logic cmp_configured,
	output logic err
);
	import cmp_pkg::*;

	logic active;       // payload of this type seen since last pkt_end
	logic hdr_done;     // count word parsed
	logic [1:0] pos;    // byte within 4-byte word
	hash_num_t count;
	hash_num_t num;     // hashes received so far
	logic [23:0] asm_r;

	wire count_bad = (count == '0) | (count > HASH_COUNT_MAX);
	wire hash_last = wr_en & hdr_done & (pos == 2'd3);

	always_ff @(posedge PKT_COMM_CLK or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			hdr_done <= 1'b0;
			pos <= 2'd0;
			count <= '0;
			num <= '0;
			tbl_wr_en <= 1'b0;
			hash_count <= '0;
			cmp_configured <= 1'b0;
			err <= 1'b0;
		end else begin
			tbl_wr_en <= 1'b0;
			if (wr_en) begin
				active <= 1'b1;
				pos <= pos + 1'b1;
				if (!hdr_done) begin
					if (pos == 2'd0)
						count[7:0] <= din;
					if (pos == 2'd1)
						count[15:8] <= din;
					if (pos == 2'd3) begin   // reserved bytes done
						hdr_done <= 1'b1;
						if (count_bad)
							err <= 1'b1;
					end
				end else if (pos == 2'd3) begin
					num <= num + 1'b1;
					if (num >= count)
						err <= 1'b1;          // more hashes than count
					else if (!count_bad)
						tbl_wr_en <= 1'b1;
				end
			end
			if (pkt_end & active) begin
				if (num != count)
					err <= 1'b1;              // payload too short
				else if (!err) begin
					hash_count <= count;      // new table takes effect
					cmp_configured <= 1'b1;
				end
				active <= 1'b0;
				hdr_done <= 1'b0;
				pos <= 2'd0;
				num <= '0;
			end
		end
	end

	always_ff @(posedge PKT_COMM_CLK) begin
		if (wr_en)
			asm_r <= {din, asm_r[23:8]};
		if (hash_last) begin
			tbl_addr <= num;
			tbl_din <= {din, asm_r};
		end
	end

endmodule

`default_nettype wire

// File: source/cmp_pkg.sv
`default_nettype none

package cmp_pkg;

	// ****************************************
	// comparator path types
	// ****************************************

	// upper bound on table address bits
	localparam int HASH_ADDR_BITS_MAX = 16;

	// candidate and table entry, 32 bits of the hash
	typedef logic [31:0] hash_t;

	// candidate index within a packet, also the processed count
	typedef logic [31:0] word_num_t;

	// position in the hash table
	typedef logic [HASH_ADDR_BITS_MAX-1:0] hash_num_t;

endpackage

`default_nettype wire

// File: source/comparator.sv
`timescale 1ns/1ns
`default_nettype none

module comparator #(
	parameter int HASH_COUNT_MAX = 16
)(
	input wire PKT_COMM_CLK,
	input wire rst_n,
	input wire tbl_wr_en,
	input wire cmp_pkg::hash_num_t tbl_addr,
	input wire cmp_pkg::hash_t tbl_din,
	input wire cmp_pkg::hash_num_t hash_count,
	input wire cmp_pkg::hash_t cand,
	input wire cand_start,
	output logic res_valid,
	output logic res_found,
	output cmp_pkg::hash_num_t res_hash_num,
	input wire res_ack
);
	import cmp_pkg::*;

	localparam int AW = (HASH_COUNT_MAX > 1) ? $clog2(HASH_COUNT_MAX) : 1;

	hash_t tbl [HASH_COUNT_MAX];
	hash_t cand_r;
	hash_num_t pos;     // scan position, frozen on a hit
	logic busy;

	wire hash_t entry = tbl[pos[AW-1:0]];

	assign res_hash_num = pos;

	always_ff @(posedge PKT_COMM_CLK) begin
		if (tbl_wr_en)
			tbl[tbl_addr[AW-1:0]] <= tbl_din;
		if (cand_start)
			cand_r <= cand;
	end

	always_ff @(posedge PKT_COMM_CLK or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			pos <= '0;
			res_valid <= 1'b0;
			res_found <= 1'b0;
		end else begin
			// a miss lasts one cycle, a hit waits for outpkt
			if (res_valid & (~res_found | res_ack))
				res_valid <= 1'b0;
			if (cand_start) begin
				busy <= 1'b1;
				pos <= '0;
			end else if (busy) begin
				if (pos == hash_count) begin   // end of table
					busy <= 1'b0;
					res_valid <= 1'b1;
					res_found <= 1'b0;
				end else if (entry == cand_r) begin
					busy <= 1'b0;
					res_valid <= 1'b1;
					res_found <= 1'b1;
				end else
					pos <= pos + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/inpkt_header.sv
`timescale 1ns/1ns
`default_nettype none

module inpkt_header #(
	parameter pkt_comm_pkg::pkt_type_t VERSION = pkt_comm_pkg::PKT_COMM_VERSION,
	parameter int PKT_MAX_LEN = 4096
)(
	input wire PKT_COMM_CLK,
	input wire rst_n,
	input wire [7:0] din,
	input wire rd_en,                         // byte taken this cycle
	output pkt_comm_pkg::pkt_type_t pkt_type,
	output pkt_comm_pkg::pkt_id_t pkt_id,
	output logic pkt_data,                    // current byte is payload
	output logic pkt_end,
	output logic err_pkt_version,
	output logic err_pkt_type,
	output logic err_pkt_len,
	output logic err_pkt_checksum
);
	import pkt_comm_pkg::*;

	typedef enum logic [1:0] {
		ST_HEADER,
		ST_HDR_CSUM,
		ST_PAYLOAD,
		ST_DATA_CSUM
	} state_t;

	state_t state;
	pkt_len_t cnt;        // byte within current phase
	pkt_len_t len;
	logic [23:0] asm_r;   // lower 3 bytes of the word in progress
	checksum_t sum;

	wire halted = err_pkt_version | err_pkt_type | err_pkt_len | err_pkt_checksum;
	wire take = rd_en & ~halted;
	wire checksum_t word_in = {din, asm_r};  // little-endian word with the last byte on top
	wire word_last = cnt[1:0] == 2'd3;
	wire pkt_len_t len_in = {din, len[15:0]};

	// only WORD_LIST and CMP_CONFIG are handled here
	wire bad_type = (din != PKT_TYPE_WORD_LIST) & (din != PKT_TYPE_CMP_CONFIG);
	wire bad_len = (len_in == '0) | (len_in[1:0] != 2'b00) | (len_in > PKT_MAX_LEN);

	assign pkt_data = (state == ST_PAYLOAD) & ~halted;

	always_ff @(posedge PKT_COMM_CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_HEADER;
			cnt <= '0;
			sum <= '0;
			pkt_type <= '0;
			pkt_end <= 1'b0;
			err_pkt_version <= 1'b0;
			err_pkt_type <= 1'b0;
			err_pkt_len <= 1'b0;
			err_pkt_checksum <= 1'b0;
		end else begin
			pkt_end <= 1'b0;
			if (take) begin
				cnt <= cnt + 1'b1;
				case (state)
				ST_HEADER: begin
					if (word_last)
						sum <= sum + word_in;
					if (cnt[2:0] == 3'd0 && din != VERSION)
						err_pkt_version <= 1'b1;
					if (cnt[2:0] == 3'd1) begin
						pkt_type <= din;
						err_pkt_type <= bad_type;
					end
					if (cnt[2:0] == 3'd6)
						err_pkt_len <= bad_len;   // length complete here
					if (cnt[2:0] == 3'd7) begin
						cnt <= '0;
						state <= ST_HDR_CSUM;
					end
				end
				ST_HDR_CSUM: if (word_last) begin
					if (word_in != ~sum)
						err_pkt_checksum <= 1'b1;
					sum <= '0;
					cnt <= '0;
					state <= ST_PAYLOAD;
				end
				ST_PAYLOAD: begin
					if (word_last)
						sum <= sum + word_in;
					if (cnt == len - 1'b1) begin
						cnt <= '0;
						state <= ST_DATA_CSUM;
					end
				end
				default: if (word_last) begin   // payload checksum
					if (word_in != ~sum)
						err_pkt_checksum <= 1'b1;
					else
						pkt_end <= 1'b1;
					sum <= '0;
					cnt <= '0;
					state <= ST_HEADER;
				end
				endcase
			end
		end
	end

	// header fields and word assembly
	always_ff @(posedge PKT_COMM_CLK) begin
		if (take) begin
			asm_r <= {din, asm_r[23:8]};
			if (state == ST_HEADER) begin
				case (cnt[2:0])
				3'd2: pkt_id[7:0] <= din;
				3'd3: pkt_id[15:8] <= din;
				3'd4: len[7:0] <= din;
				3'd5: len[15:8] <= din;
				3'd6: len[23:16] <= din;
				default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: source/md5crypt_cmp.sv
`timescale 1ns/1ns
`default_nettype none

module md5crypt_cmp #(
	parameter pkt_comm_pkg::pkt_type_t VERSION = pkt_comm_pkg::PKT_COMM_VERSION,
	parameter int PKT_MAX_LEN = 4096,
	parameter int HASH_COUNT_MAX = 16
)(
	input wire PKT_COMM_CLK,
	input wire rst_n,
	input wire [7:0] din,                   // from input fifo
	output logic rd_en,
	input wire empty,
	output pkt_comm_pkg::out_word_t dout,   // to output fifo
	output logic wr_en,
	input wire full,
	output logic [7:0] pkt_comm_status,
	output logic [7:0] app_status
);
	import pkt_comm_pkg::*;
	import cmp_pkg::*;

	pkt_type_t inpkt_type;
	pkt_id_t inpkt_id;
	logic inpkt_data;
	logic inpkt_end;
	logic err_pkt_version;
	logic err_pkt_type;
	logic err_pkt_len;
	logic err_pkt_checksum;
	logic err_cmp_config;
	logic err_unconfigured;
	logic tbl_wr_en;
	hash_num_t tbl_addr;
	hash_t tbl_din;
	hash_num_t hash_count;
	logic cmp_configured;
	hash_t cand;
	logic cand_start;
	word_num_t cand_num;
	logic res_valid;
	logic res_found;
	hash_num_t res_hash_num;
	logic res_ack;
	logic word_list_ready;
	logic done_req;
	word_num_t done_num;
	pkt_id_t done_pkt_id;
	logic done_ack;
	logic out_valid;

	// ****************************************
	// input side, byte dispatch
	// ****************************************
	wire inpkt_halt = err_pkt_version | err_pkt_type | err_pkt_len | err_pkt_checksum;
	wire is_cmp_config = inpkt_type == PKT_TYPE_CMP_CONFIG;
	wire is_word_list = inpkt_type == PKT_TYPE_WORD_LIST;

	// header/checksum bytes always go, payload only if its handler takes it
	assign rd_en = ~empty & ~inpkt_halt
		& (~inpkt_data | is_cmp_config | (is_word_list & word_list_ready));

	wire cmp_config_wr_en = rd_en & inpkt_data & is_cmp_config;
	wire word_list_wr_en = rd_en & inpkt_data & is_word_list;

	inpkt_header #(
		.VERSION(VERSION), .PKT_MAX_LEN(PKT_MAX_LEN)
	) inpkt_header (
		.PKT_COMM_CLK(PKT_COMM_CLK), .rst_n(rst_n),
		.din(din), .rd_en(rd_en),
		.pkt_type(inpkt_type), .pkt_id(inpkt_id),
		.pkt_data(inpkt_data), .pkt_end(inpkt_end),
		.err_pkt_version(err_pkt_version), .err_pkt_type(err_pkt_type),
		.err_pkt_len(err_pkt_len), .err_pkt_checksum(err_pkt_checksum)
	);

	cmp_config #( .HASH_COUNT_MAX(HASH_COUNT_MAX) ) cmp_config (
		.PKT_COMM_CLK(PKT_COMM_CLK), .rst_n(rst_n),
		.din(din), .wr_en(cmp_config_wr_en), .pkt_end(inpkt_end),
		.tbl_wr_en(tbl_wr_en), .tbl_addr(tbl_addr), .tbl_din(tbl_din),
		.hash_count(hash_count), .cmp_configured(cmp_configured),
		.err(err_cmp_config)
	);

	comparator #( .HASH_COUNT_MAX(HASH_COUNT_MAX) ) comparator (
		.PKT_COMM_CLK(PKT_COMM_CLK), .rst_n(rst_n),
		.tbl_wr_en(tbl_wr_en), .tbl_addr(tbl_addr), .tbl_din(tbl_din),
		.hash_count(hash_count),
		.cand(cand), .cand_start(cand_start),
		.res_valid(res_valid), .res_found(res_found),
		.res_hash_num(res_hash_num), .res_ack(res_ack)
	);

	word_list word_list (
		.PKT_COMM_CLK(PKT_COMM_CLK), .rst_n(rst_n),
		.din(din), .wr_en(word_list_wr_en), .pkt_end(inpkt_end),
		.pkt_id(inpkt_id), .ready(word_list_ready),
		.cmp_configured(cmp_configured),
		.cand(cand), .cand_start(cand_start), .cand_num(cand_num),
		.res_valid(res_valid),
		.done_req(done_req), .done_num(done_num), .done_pkt_id(done_pkt_id),
		.done_ack(done_ack), .err_unconfigured(err_unconfigured)
	);

	// ****************************************
	// output packets
	// ****************************************
	outpkt #( .VERSION(VERSION) ) outpkt (
		.PKT_COMM_CLK(PKT_COMM_CLK), .rst_n(rst_n),
		.res_valid(res_valid), .res_found(res_found),
		.res_hash_num(res_hash_num), .cand_num(cand_num),
		.done_pkt_id(done_pkt_id), .res_ack(res_ack),
		.done_req(done_req), .done_num(done_num), .done_ack(done_ack),
		.dout(dout), .dout_valid(out_valid), .full(full)
	);

	assign wr_en = out_valid & ~full;

	// status bytes, unused bits stay 0
	always_comb begin
		pkt_comm_status = 8'h00;
		pkt_comm_status[ERR_INPKT_CHECKSUM] = err_pkt_checksum;
		pkt_comm_status[ERR_INPKT_LEN] = err_pkt_len;
		pkt_comm_status[ERR_INPKT_TYPE] = err_pkt_type;
		pkt_comm_status[ERR_PKT_VERSION] = err_pkt_version;
		pkt_comm_status[ERR_CMP_CONFIG] = err_cmp_config;
		app_status = 8'h00;
		app_status[ERR_CMP_UNCONFIGURED] = err_unconfigured;
	end

endmodule

`default_nettype wire

// File: source/outpkt.sv
`timescale 1ns/1ns
`default_nettype none

module outpkt #(
	parameter pkt_comm_pkg::pkt_type_t VERSION = pkt_comm_pkg::PKT_COMM_VERSION
)(
	input wire PKT_COMM_CLK,
	input wire rst_n,
	input wire res_valid,
	input wire res_found,
	input wire cmp_pkg::hash_num_t res_hash_num,
	input wire cmp_pkg::word_num_t cand_num,
	input wire pkt_comm_pkg::pkt_id_t done_pkt_id,
	output logic res_ack,
	input wire done_req,
	input wire cmp_pkg::word_num_t done_num,
	output logic done_ack,
	output pkt_comm_pkg::out_word_t dout,
	output logic dout_valid,
	input wire full
);
	import pkt_comm_pkg::*;
	import cmp_pkg::*;

	localparam logic [31:0] PAYLOAD_LEN = 32'd8;   // bytes, both packet types

	logic busy;
	logic [3:0] cnt;      // word in packet, 0..11
	pkt_type_t type_r;
	pkt_id_t id_r;
	word_num_t val_r;     // candidate index or processed count
	hash_num_t hn_r;
	checksum_t sum;
	out_word_t lo;        // low half of the word pair

	wire take_res = res_valid & res_found;
	wire start = ~busy & (take_res | done_req);

	// result first when both are waiting
	assign res_ack = ~busy & take_res;
	assign done_ack = ~busy & done_req & ~take_res;
	assign dout_valid = busy;

	// ****************************************
	// word sequence
	// ****************************************
	always_comb begin
		case (cnt)
		4'd0: dout = {type_r, VERSION};
		4'd1: dout = id_r;
		4'd2: dout = PAYLOAD_LEN[15:0];
		4'd3: dout = PAYLOAD_LEN[31:16];
		4'd4, 4'd10: dout = ~sum[15:0];    // checksum, low word first
		4'd5, 4'd11: dout = ~sum[31:16];
		4'd6: dout = val_r[15:0];
		4'd7: dout = val_r[31:16];
		4'd8: dout = hn_r;
		default: dout = 16'h0000;
		endcase
	end

	always_ff @(posedge PKT_COMM_CLK or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= 4'd0;
			sum <= '0;
		end else if (!busy) begin
			cnt <= 4'd0;
			sum <= '0;
			if (start)
				busy <= 1'b1;
		end else if (!full) begin
			cnt <= cnt + 1'b1;
			case (cnt)
			4'd5: sum <= '0;           // header done, restart for payload
			4'd11: busy <= 1'b0;
			default: if (cnt[0])
				sum <= sum + {dout, lo};
			endcase
		end
	end

	always_ff @(posedge PKT_COMM_CLK) begin
		if (busy & ~full & ~cnt[0])
			lo <= dout;
		if (start) begin
			id_r <= done_pkt_id;
			if (take_res) begin
				type_r <= OUTPKT_TYPE_CMP_RESULT;
				val_r <= cand_num;
				hn_r <= res_hash_num;
			end else begin
				type_r <= OUTPKT_TYPE_PROCESSING_DONE;
				val_r <= done_num;
				hn_r <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/pkt_comm_pkg.sv
`default_nettype none

package pkt_comm_pkg;

	// ****************************************
	// packet format
	// ****************************************
	typedef logic [7:0] pkt_type_t;
	typedef logic [15:0] pkt_id_t;
	typedef logic [23:0] pkt_len_t;   // payload length in bytes
	typedef logic [31:0] checksum_t;
	typedef logic [15:0] out_word_t;  // output fifo width

	localparam pkt_type_t PKT_COMM_VERSION = 8'd2;

	// input packet types
	localparam pkt_type_t PKT_TYPE_WORD_LIST = 8'd1;
	localparam pkt_type_t PKT_TYPE_CMP_CONFIG = 8'd3;
	localparam int PKT_MAX_TYPE = 6;

	// output packet types
	localparam pkt_type_t OUTPKT_TYPE_CMP_RESULT = 8'hD4;
	localparam pkt_type_t OUTPKT_TYPE_PROCESSING_DONE = 8'hD2;

	// ****************************************
	// error bit positions
	// ****************************************
	localparam int ERR_INPKT_CHECKSUM = 0;   // pkt_comm_status 0x01
	localparam int ERR_INPKT_LEN = 1;        // 0x02
	localparam int ERR_INPKT_TYPE = 2;       // 0x04
	localparam int ERR_PKT_VERSION = 3;      // 0x08
	localparam int ERR_CMP_CONFIG = 7;       // 0x80
	localparam int ERR_CMP_UNCONFIGURED = 0; // app_status 0x01

endpackage

`default_nettype wire

// File: source/word_list.sv
`timescale 1ns/1ns
`default_nettype none

module word_list (
	input wire PKT_COMM_CLK,
	input wire rst_n,
	input wire [7:0] din,
	input wire wr_en,                          // WORD_LIST payload byte
	input wire pkt_end,
	input wire pkt_comm_pkg::pkt_id_t pkt_id,
	output logic ready,
	input wire cmp_configured,
	output cmp_pkg::hash_t cand,
	output logic cand_start,
	output cmp_pkg::word_num_t cand_num,
	input wire res_valid,
	output logic done_req,
	output cmp_pkg::word_num_t done_num,
	output pkt_comm_pkg::pkt_id_t done_pkt_id,
	input wire done_ack,
	output logic err_unconfigured
);
	import cmp_pkg::*;

	logic active;       // inside a WORD_LIST payload
	logic pending;      // lookup in flight
	logic got_res;      // res_valid seen, waiting for it to drop
	logic done_pend;
	logic [1:0] pos;
	logic [23:0] asm_r;
	word_num_t num;     // candidates in this packet so far

	wire cand_last = wr_en & (pos == 2'd3);

	// next list held off until the done packet is taken
	assign ready = ~pending & ~done_pend;
	assign done_req = done_pend & ~pending;   // last result goes first

	always_ff @(posedge PKT_COMM_CLK or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			pending <= 1'b0;
			got_res <= 1'b0;
			done_pend <= 1'b0;
			pos <= 2'd0;
			num <= '0;
			cand_start <= 1'b0;
			err_unconfigured <= 1'b0;
		end else begin
			cand_start <= 1'b0;
			if (pending) begin
				if (res_valid)
					got_res <= 1'b1;
				else if (got_res) begin   // result dropped, outpkt has it
					pending <= 1'b0;
					got_res <= 1'b0;
				end
			end
			if (wr_en) begin
				active <= 1'b1;
				pos <= pos + 1'b1;
			end
			if (cand_last) begin
				num <= num + 1'b1;
				if (cmp_configured) begin
					cand_start <= 1'b1;
					pending <= 1'b1;
				end else
					err_unconfigured <= 1'b1;   // counted, not compared
			end
			if (done_ack)
				done_pend <= 1'b0;
			if (pkt_end & active) begin
				done_pend <= 1'b1;
				active <= 1'b0;
				pos <= 2'd0;
				num <= '0;
			end
		end
	end

	always_ff @(posedge PKT_COMM_CLK) begin
		if (wr_en)
			asm_r <= {din, asm_r[23:8]};
		if (wr_en & ~active)
			done_pkt_id <= pkt_id;   // first payload byte
		if (cand_last) begin
			cand <= {din, asm_r};
			cand_num <= num;
		end
		if (pkt_end & active)
			done_num <= num;
	end

endmodule

`default_nettype wire

// File: include/tb_pkt_tasks.svh
`ifndef TB_PKT_TASKS_SVH
`define TB_PKT_TASKS_SVH

// ****************************************
// input packet builders
// ****************************************

// 32-bit value into the payload, low byte first
task automatic pay_le32(input logic [31:0] w);
	pay_q.push_back(w[7:0]);
	pay_q.push_back(w[15:8]);
	pay_q.push_back(w[23:16]);
	pay_q.push_back(w[31:24]);
endtask

// same byte order, straight into the input FIFO model
task automatic fifo_le32(input logic [31:0] w);
	in_q.push_back(w[7:0]);
	in_q.push_back(w[15:8]);
	in_q.push_back(w[23:16]);
	in_q.push_back(w[31:24]);
endtask

// header, header checksum, payload taken from pay_q, payload checksum
task automatic send_packet(input pkt_type_t ver, input pkt_type_t typ, input pkt_id_t id,
		input pkt_len_t len, input bit bad_csum);
	logic [7:0] hdr [8];
	checksum_t hsum;
	checksum_t psum;
	int i;
	hdr[0] = ver;
	hdr[1] = typ;
	hdr[2] = id[7:0];
	hdr[3] = id[15:8];
	hdr[4] = len[7:0];
	hdr[5] = len[15:8];
	hdr[6] = len[23:16];
	hdr[7] = 8'h00;   // reserved
	hsum = {hdr[3], hdr[2], hdr[1], hdr[0]} + {hdr[7], hdr[6], hdr[5], hdr[4]};
	psum = '0;
	for (i = 0; i + 3 < pay_q.size(); i += 4)
		psum = psum + {pay_q[i+3], pay_q[i+2], pay_q[i+1], pay_q[i]};
	for (i = 0; i < 8; i++)
		in_q.push_back(hdr[i]);
	fifo_le32(~hsum);
	for (i = 0; i < pay_q.size(); i++)
		in_q.push_back(pay_q[i]);
	fifo_le32(~psum ^ {31'd0, bad_csum});   // bit 0 flipped when corrupting
	pay_q.delete();
endtask

// count, two reserved bytes, then every entry of hash_list
task automatic send_cmp_config(input pkt_id_t id);
	int i;
	pay_q.delete();
	pay_le32({16'h0000, 16'(hash_list.size())});
	for (i = 0; i < hash_list.size(); i++)
		pay_le32(hash_list[i]);
	send_packet(VERSION, PKT_TYPE_CMP_CONFIG, id, pkt_len_t'(pay_q.size()), 1'b0);
endtask

// one 4-byte candidate per entry of cand_list
task automatic send_word_list(input pkt_id_t id, input bit bad_csum);
	int i;
	pay_q.delete();
	for (i = 0; i < cand_list.size(); i++)
		pay_le32(cand_list[i]);
	send_packet(VERSION, PKT_TYPE_WORD_LIST, id, pkt_len_t'(pay_q.size()), bad_csum);
endtask

`endif

// File: testbench/tb_md5crypt_cmp.sv
`timescale 1ns/1ns
`default_nettype none

module tb_md5crypt_cmp;
	import pkt_comm_pkg::*;
	import cmp_pkg::*;

	localparam pkt_type_t VERSION = PKT_COMM_VERSION;
	localparam int PKT_MAX_LEN = 4096;
	localparam int HASH_COUNT_MAX = 16;
	localparam int TEST_COUNT = 6;
	localparam int TIMEOUT_CYCLES = TEST_COUNT * 2000;   // 2000 cycles per test task

	logic PKT_COMM_CLK = 1'b0;
	logic rst_n = 1'b0;
	logic [7:0] din = 8'h00;
	logic empty = 1'b1;
	logic full = 1'b0;
	logic rd_en;
	out_word_t dout;
	logic wr_en;
	logic [7:0] pkt_comm_status;
	logic [7:0] app_status;

	logic [7:0] in_q [$];    // input FIFO contents
	logic [7:0] pay_q [$];   // payload being built
	out_word_t out_q [$];    // words written by the DUT
	hash_t hash_list [$];
	hash_t cand_list [$];
	integer seed = 32'h3bc3_a0d0;
	logic [31:0] rnd;
	bit rand_full = 1'b0;    // back-pressure on/off
	int cycles = 0;

	`include "tb_pkt_tasks.svh"

	md5crypt_cmp #(
		.VERSION(VERSION), .PKT_MAX_LEN(PKT_MAX_LEN), .HASH_COUNT_MAX(HASH_COUNT_MAX)
	) md5crypt_cmp_i (
		.PKT_COMM_CLK(PKT_COMM_CLK), .rst_n(rst_n),
		.din(din), .rd_en(rd_en), .empty(empty),
		.dout(dout), .wr_en(wr_en), .full(full),
		.pkt_comm_status(pkt_comm_status), .app_status(app_status)
	);

	always #2 PKT_COMM_CLK = ~PKT_COMM_CLK;   // 4 ns period

	// ****************************************
	// FIFO models and monitor
	// ****************************************
	always @(posedge PKT_COMM_CLK) begin
		if (!rst_n) begin
			din <= 8'h00;
			empty <= 1'b1;
		end else begin
			if (rd_en && !empty && in_q.size() != 0)
				void'(in_q.pop_front());   // byte taken at this edge
			if (in_q.size() != 0) begin
				din <= in_q[0];
				empty <= 1'b0;
			end else
				empty <= 1'b1;
		end
	end

	always @(posedge PKT_COMM_CLK) begin
		rnd = $random(seed);
		full <= rand_full & rnd[0];
	end

	always @(posedge PKT_COMM_CLK) begin
		if (rst_n && wr_en)
			out_q.push_back(dout);
	end

	always @(posedge PKT_COMM_CLK) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			fail_run($sformatf("timeout, run still going after %0d cycles", cycles));
	end

	// ****************************************
	// checks
	// ****************************************
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input out_word_t got, input out_word_t exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_status(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_count(input string name, input word_num_t got, input word_num_t exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic do_reset();
		in_q.delete();
		rst_n <= 1'b0;
		repeat (2) @(posedge PKT_COMM_CLK);
		rst_n <= 1'b1;
		repeat (2) @(posedge PKT_COMM_CLK);
		out_q.delete();
		check_status("pkt_comm_status", pkt_comm_status, 8'h00);
		check_status("app_status", app_status, 8'h00);
		if (rd_en || wr_en)
			fail_run("rd_en or wr_en is high right after reset");
	endtask

	task automatic wait_drained();
		while (in_q.size() != 0 || !empty)
			@(posedge PKT_COMM_CLK);
	endtask

	task automatic wait_error();
		while (pkt_comm_status == 8'h00)
			@(posedge PKT_COMM_CLK);
	endtask

	// expected words built from the output format, then compared one by one
	task automatic expect_out_pkt(input string what, input pkt_type_t typ, input pkt_id_t id,
			input word_num_t val, input hash_num_t hn);
		out_word_t exp [12];
		out_word_t got [12];
		checksum_t hsum;
		checksum_t psum;
		int i;
		exp[0] = {typ, VERSION};
		exp[1] = id;
		exp[2] = 16'd8;    // payload length low
		exp[3] = 16'd0;
		hsum = ~({exp[1], exp[0]} + {exp[3], exp[2]});
		exp[4] = hsum[15:0];
		exp[5] = hsum[31:16];
		exp[6] = val[15:0];
		exp[7] = val[31:16];
		exp[8] = hn;
		exp[9] = 16'h0000;
		psum = ~({exp[7], exp[6]} + {exp[9], exp[8]});
		exp[10] = psum[15:0];
		exp[11] = psum[31:16];
		while (out_q.size() < 12)
			@(posedge PKT_COMM_CLK);
		for (i = 0; i < 12; i++)
			got[i] = out_q.pop_front();
		check_count({"index or count of ", what}, {got[7], got[6]}, val);
		for (i = 0; i < 12; i++)
			check_word($sformatf("dout word %0d of %s", i, what), got[i], exp[i]);
	endtask

	task automatic expect_quiet(input int n);
		repeat (n) @(posedge PKT_COMM_CLK);
		if (out_q.size() != 0)
			fail_run($sformatf("%0d output words appeared where none were due", out_q.size()));
	endtask

	function automatic hash_t table_hash(input int i);
		return 32'hA5A5_0000 + 32'h0001_1111 * i;
	endfunction

	task automatic fill_table(input int n);
		int i;
		hash_list.delete();
		for (i = 0; i < n; i++)
			hash_list.push_back(table_hash(i));
	endtask

	// ****************************************
	// directed tests
	// ****************************************
	task automatic test_match_list();
		int i;
		do_reset();
		fill_table(5);
		send_cmp_config(16'h0A01);
		cand_list.delete();
		for (i = 0; i < 8; i++)
			cand_list.push_back(32'h1234_0000 + i);
		cand_list[1] = table_hash(2);
		cand_list[4] = table_hash(0);
		cand_list[6] = table_hash(4);
		send_word_list(16'hA11A, 1'b0);
		expect_out_pkt("CMP_RESULT 1", OUTPKT_TYPE_CMP_RESULT, 16'hA11A, 1, 2);
		expect_out_pkt("CMP_RESULT 4", OUTPKT_TYPE_CMP_RESULT, 16'hA11A, 4, 0);
		expect_out_pkt("CMP_RESULT 6", OUTPKT_TYPE_CMP_RESULT, 16'hA11A, 6, 4);
		expect_out_pkt("PROCESSING_DONE", OUTPKT_TYPE_PROCESSING_DONE, 16'hA11A, 8, 0);
		expect_quiet(40);
		check_status("pkt_comm_status", pkt_comm_status, 8'h00);
		check_status("app_status", app_status, 8'h00);
	endtask

	// table from the previous test still loaded
	task automatic test_no_match_backpressure();
		int i;
		rand_full = 1'b1;
		cand_list.delete();
		for (i = 0; i < 6; i++)
			cand_list.push_back(32'h7777_0000 + 3 * i);
		send_word_list(16'h0B0B, 1'b0);
		expect_out_pkt("PROCESSING_DONE", OUTPKT_TYPE_PROCESSING_DONE, 16'h0B0B, 6, 0);
		expect_quiet(60);
		rand_full = 1'b0;
		check_status("pkt_comm_status", pkt_comm_status, 8'h00);
	endtask

	task automatic test_unconfigured();
		int i;
		do_reset();
		cand_list.delete();
		for (i = 0; i < 5; i++)
			cand_list.push_back(table_hash(i));
		send_word_list(16'h0C0C, 1'b0);
		expect_out_pkt("PROCESSING_DONE", OUTPKT_TYPE_PROCESSING_DONE, 16'h0C0C, 5, 0);
		wait_drained();
		expect_quiet(20);
		check_status("app_status", app_status, 8'h01);
		check_status("pkt_comm_status", pkt_comm_status, 8'h00);
	endtask

	task automatic test_bad_checksum();
		int i;
		do_reset();
		fill_table(5);
		send_cmp_config(16'h0D01);
		cand_list.delete();
		for (i = 0; i < 4; i++)
			cand_list.push_back(32'h5500_0000 + i);
		send_word_list(16'h0D02, 1'b1);
		send_word_list(16'h0D03, 1'b0);   // queued behind, never read
		wait_error();
		check_status("pkt_comm_status", pkt_comm_status, 8'h01);
		repeat (50) begin
			@(posedge PKT_COMM_CLK);
			if (rd_en)
				fail_run("rd_en went high again after a payload checksum error");
		end
		if (in_q.size() == 0)
			fail_run("input FIFO drained after a payload checksum error");
		expect_quiet(0);
		do_reset();
	endtask

	// fresh reset, one bad header field, one error bit
	task automatic bad_header_case(input pkt_type_t ver, input pkt_type_t typ,
			input pkt_len_t len, input logic [7:0] exp_status);
		int i;
		do_reset();
		pay_q.delete();
		for (i = 0; i < len; i++)
			pay_q.push_back(8'(i));
		send_packet(ver, typ, 16'h0E00, len, 1'b0);
		wait_error();
		repeat (4) @(posedge PKT_COMM_CLK);
		check_status("pkt_comm_status", pkt_comm_status, exp_status);
		expect_quiet(10);
	endtask

	task automatic test_bad_headers();
		bad_header_case(8'd3, PKT_TYPE_WORD_LIST, 24'd4, 8'h08);   // version
		bad_header_case(VERSION, 8'd2, 24'd4, 8'h04);              // type
		bad_header_case(VERSION, PKT_TYPE_WORD_LIST, 24'd6, 8'h02); // length
	endtask

	task automatic test_config_overflow();
		do_reset();
		fill_table(HASH_COUNT_MAX + 1);
		send_cmp_config(16'h0F01);
		wait_drained();
		repeat (5) @(posedge PKT_COMM_CLK);
		check_status("pkt_comm_status", pkt_comm_status, 8'h80);
		check_status("app_status", app_status, 8'h00);
	endtask

	initial begin
		test_match_list();
		test_no_match_backpressure();
		test_unconfigured();
		test_bad_checksum();
		test_bad_headers();
		test_config_overflow();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
